// File: rx_framer_pkg.sv
package rx_framer_pkg;

   // one received sample and one 64-bit output or storage word
   typedef logic [31:0] sample_t;
   typedef logic [63:0] beat_t;
   typedef logic [63:0] vita_time_t;
   typedef logic [31:0] sid_t;

   // the header sequence field is 12 bits wide and wraps
   typedef logic [11:0] seqnum_t;
   typedef logic [15:0] pkt_len_t;
   typedef logic [15:0] space_t;

   // header store entry, from the top: eob, length, timestamp
   typedef logic [80:0] hdr_entry_t;

   // data store entry, with the last flag above the beat
   typedef logic [64:0] data_entry_t;

   // settings bus addresses
   localparam logic [7:0] SET_ADDR_MAXLEN = 8'd0;
   localparam logic [7:0] SET_ADDR_SID    = 8'd1;

   // store depths as log2 of the entry count
   localparam int DATA_FIFO_LOG2 = 5;
   localparam int HDR_FIFO_LOG2  = 2;

   // full is raised while the data store has this many free entries or fewer
   localparam space_t FULL_MARGIN = 16'd2;

   // credits held by the assembler after reset, and the upper bound
   localparam int CREDIT_MAX = 8;

   // top three bits of every header word
   localparam logic [2:0] HDR_FLAGS = 3'b001;

endpackage

// File: rx_framer_top.sv
module rx_framer_top (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic                      i_clear,
   input  logic                      i_set_stb,
   input  logic [7:0]                i_set_addr,
   input  logic [31:0]               i_set_data,
   input  logic                      i_strobe,
   input  rx_framer_pkg::sample_t    i_sample,
   input  logic                      i_run,
   input  logic                      i_eob,
   input  rx_framer_pkg::vita_time_t i_vita_time,
   output logic                      o_full,
   output rx_framer_pkg::seqnum_t    o_seqnum,
   output logic                      o_valid,
   output rx_framer_pkg::beat_t      o_data,
   output logic                      o_last,
   input  logic                      i_credit
);
   import rx_framer_pkg::*;

   logic        sample_take;
   logic        pkt_end;
   logic        dfifo_wr;
   logic        dfifo_rd;
   logic        dfifo_not_empty;
   space_t      dfifo_space;
   data_entry_t dfifo_wr_data;
   data_entry_t dfifo_rd_data;
   logic        hfifo_wr;
   logic        hfifo_rd;
   logic        hfifo_not_empty;
   logic        hfifo_full;
   hdr_entry_t  hfifo_wr_data;
   hdr_entry_t  hfifo_rd_data;

   rx_sample_packer packer (
      .clk(clk), .i_rst_n(i_rst_n), .i_clear(i_clear),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_strobe(i_strobe), .i_run(i_run), .i_eob(i_eob), .i_sample(i_sample),
      .i_dfifo_space(dfifo_space), .i_hfifo_full(hfifo_full), .o_full(o_full),
      .o_sample_take(sample_take), .o_pkt_end(pkt_end),
      .o_dfifo_wr(dfifo_wr), .o_dfifo_data(dfifo_wr_data)
   );

   rx_header_recorder recorder (
      .clk(clk), .i_rst_n(i_rst_n), .i_clear(i_clear),
      .i_sample_take(sample_take), .i_pkt_end(pkt_end), .i_eob(i_eob),
      .i_vita_time(i_vita_time), .o_hfifo_wr(hfifo_wr), .o_hfifo_data(hfifo_wr_data)
   );

   rx_sync_fifo #(.WIDTH($bits(data_entry_t)), .DEPTH_LOG2(DATA_FIFO_LOG2)) data_fifo (
      .clk(clk), .i_rst_n(i_rst_n), .i_clear(i_clear),
      .i_wr_en(dfifo_wr), .i_wr_data(dfifo_wr_data),
      .i_rd_en(dfifo_rd), .o_rd_data(dfifo_rd_data),
      .o_not_empty(dfifo_not_empty), .o_full(), .o_space(dfifo_space)
   );

   rx_sync_fifo #(.WIDTH($bits(hdr_entry_t)), .DEPTH_LOG2(HDR_FIFO_LOG2)) hdr_fifo (
      .clk(clk), .i_rst_n(i_rst_n), .i_clear(i_clear),
      .i_wr_en(hfifo_wr), .i_wr_data(hfifo_wr_data),
      .i_rd_en(hfifo_rd), .o_rd_data(hfifo_rd_data),
      .o_not_empty(hfifo_not_empty), .o_full(hfifo_full), .o_space()
   );

   rx_packet_assembler assembler (
      .clk(clk), .i_rst_n(i_rst_n), .i_clear(i_clear),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_hdr_valid(hfifo_not_empty), .i_hdr_entry(hfifo_rd_data),
      .i_data_valid(dfifo_not_empty), .i_data_entry(dfifo_rd_data),
      .i_credit(i_credit), .o_hdr_pop(hfifo_rd), .o_data_pop(dfifo_rd),
      .o_valid(o_valid), .o_data(o_data), .o_last(o_last), .o_seqnum(o_seqnum)
   );

endmodule

// File: rx_header_recorder.sv
module rx_header_recorder (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic                      i_clear,
   input  logic                      i_sample_take,
   input  logic                      i_pkt_end,
   input  logic                      i_eob,
   input  rx_framer_pkg::vita_time_t i_vita_time,
   output logic                      o_hfifo_wr,
   output rx_framer_pkg::hdr_entry_t o_hfifo_data
);
   import rx_framer_pkg::*;

   logic       in_pkt;
   pkt_len_t   count;
   pkt_len_t   pkt_len;
   vita_time_t hold_time;
   vita_time_t pkt_time;

   always_ff @(posedge clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         in_pkt <= 1'b0;
         count  <= '0;
      end
      else if (i_clear)
      begin
         in_pkt <= 1'b0;
         count  <= '0;
      end
      else if (i_sample_take)
      begin
         in_pkt <= !i_pkt_end;
         if (i_pkt_end)
            count <= '0;
         else
            count <= count + 16'd1;
      end
   end

   // timestamp of the first sample in the packet
   always_ff @(posedge clk)
   begin
      if (i_sample_take && !in_pkt)
         hold_time <= i_vita_time;
   end

   // a one-sample packet has not captured its time yet, so take it live
   assign pkt_time = in_pkt ? hold_time : i_vita_time;
   assign pkt_len  = count + 16'd1;

   assign o_hfifo_wr   = i_sample_take && i_pkt_end;
   assign o_hfifo_data = {i_eob, pkt_len, pkt_time};

endmodule

// File: rx_packet_assembler.sv
module rx_packet_assembler (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_clear,
   input  logic                       i_set_stb,
   input  logic [7:0]                 i_set_addr,
   input  logic [31:0]                i_set_data,
   input  logic                       i_hdr_valid,
   input  rx_framer_pkg::hdr_entry_t  i_hdr_entry,
   input  logic                       i_data_valid,
   input  rx_framer_pkg::data_entry_t i_data_entry,
   input  logic                       i_credit,
   output logic                       o_hdr_pop,
   output logic                       o_data_pop,
   output logic                       o_valid,
   output rx_framer_pkg::beat_t       o_data,
   output logic                       o_last,
   output rx_framer_pkg::seqnum_t     o_seqnum
);
   import rx_framer_pkg::*;

   typedef enum logic [1:0] {ASM_IDLE, ASM_HEAD, ASM_TIME, ASM_BODY} asm_state_e;
   typedef logic [$clog2(CREDIT_MAX + 1)-1:0] credit_t;

   asm_state_e state;
   sid_t       sid;
   seqnum_t    seqnum;
   credit_t    credits;
   logic       sid_wr;
   logic       have_credit;
   logic       hdr_eob;
   pkt_len_t   hdr_len;
   vita_time_t hdr_time;
   beat_t      hdr_beat;

   assign sid_wr = i_set_stb && (i_set_addr == SET_ADDR_SID);

   always_ff @(posedge clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
         sid <= '0;
      else if (sid_wr)
         sid <= i_set_data;
   end

   // a new stream identifier restarts the packet numbering
   always_ff @(posedge clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
         seqnum <= '0;
      else if (i_clear || sid_wr)
         seqnum <= '0;
      else if (o_valid && o_last)
         seqnum <= seqnum + 12'd1;
   end

   assign have_credit = (credits != '0);

   always_ff @(posedge clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
         credits <= credit_t'(CREDIT_MAX);
      else if (i_clear)
         credits <= credit_t'(CREDIT_MAX);
      else
      begin
         case ({o_valid, i_credit})
            2'b10:   credits <= credits - credit_t'(1);
            2'b01:   credits <= credits + credit_t'(1);
            default: credits <= credits;
         endcase
      end
   end

   // a header entry means the whole packet is already in the data store
   always_ff @(posedge clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
         state <= ASM_IDLE;
      else if (i_clear)
         state <= ASM_IDLE;
      else
      begin
         case (state)
            ASM_IDLE:
               if (i_hdr_valid)
                  state <= ASM_HEAD;
            ASM_HEAD:
               if (o_valid)
                  state <= ASM_TIME;
            ASM_TIME:
               if (o_valid)
                  state <= ASM_BODY;
            ASM_BODY:
               if (o_valid && o_last)
                  state <= ASM_IDLE;
            default:
               state <= ASM_IDLE;
         endcase
      end
   end

   assign hdr_eob  = i_hdr_entry[80];
   assign hdr_len  = i_hdr_entry[79:64];
   assign hdr_time = i_hdr_entry[63:0];
   assign hdr_beat = {HDR_FLAGS, hdr_eob, seqnum, hdr_len, sid};

   assign o_valid = have_credit && ((state == ASM_HEAD) || (state == ASM_TIME) ||
                                    ((state == ASM_BODY) && i_data_valid));
   assign o_last  = o_valid && (state == ASM_BODY) && i_data_entry[64];

   always_comb
   begin
      case (state)
         ASM_HEAD: o_data = hdr_beat;
         ASM_TIME: o_data = hdr_time;
         default:  o_data = i_data_entry[63:0];
      endcase
   end

   // the header entry stays at the head until its final body beat is sent
   assign o_hdr_pop  = o_valid && o_last;
   assign o_data_pop = o_valid && (state == ASM_BODY);
   assign o_seqnum   = seqnum;

   // the downstream side never returns more credits than it was given
   a_credit_bound: assert property (@(posedge clk) disable iff (!i_rst_n)
      credits <= credit_t'(CREDIT_MAX))
      else $error("credit count above its maximum");

endmodule

// File: rx_sample_packer.sv
module rx_sample_packer (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_clear,
   input  logic                       i_set_stb,
   input  logic [7:0]                 i_set_addr,
   input  logic [31:0]                i_set_data,
   input  logic                       i_strobe,
   input  logic                       i_run,
   input  logic                       i_eob,
   input  rx_framer_pkg::sample_t     i_sample,
   input  rx_framer_pkg::space_t      i_dfifo_space,
   input  logic                       i_hfifo_full,
   output logic                       o_full,
   output logic                       o_sample_take,
   output logic                       o_pkt_end,
   output logic                       o_dfifo_wr,
   output rx_framer_pkg::data_entry_t o_dfifo_data
);
   import rx_framer_pkg::*;

   typedef enum logic {PACK_EMPTY, PACK_HALF} pack_state_e;

   pack_state_e state;
   pkt_len_t    maxlen;
   pkt_len_t    count;
   sample_t     holding;
   logic        take;
   logic        at_max;

   // maximum packet length in samples
   always_ff @(posedge clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
         maxlen <= '0;
      else if (i_set_stb && (i_set_addr == SET_ADDR_MAXLEN))
         maxlen <= i_set_data[15:0];
   end

   assign take   = i_strobe && i_run;
   // count holds the samples already taken, so this sample is the maxlen-th one
   assign at_max = (count >= (maxlen - 16'd1));

   // keep two entries in reserve so that a sample taken during full still fits
   assign o_full = (i_dfifo_space <= FULL_MARGIN) || i_hfifo_full;

   assign o_sample_take = take;
   assign o_pkt_end     = take && (i_eob || at_max || o_full);

   // a word goes out once a pair is complete or the packet closes on a lone sample
   assign o_dfifo_wr   = take && ((state == PACK_HALF) || o_pkt_end);
   assign o_dfifo_data = (state == PACK_HALF) ? {o_pkt_end, holding, i_sample}
                                              : {o_pkt_end, i_sample, sample_t'(0)};

   always_ff @(posedge clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         state <= PACK_EMPTY;
         count <= '0;
      end
      else if (i_clear)
      begin
         state <= PACK_EMPTY;
         count <= '0;
      end
      else if (take)
      begin
         if (o_pkt_end)
            count <= '0;
         else
            count <= count + 16'd1;

         if (state == PACK_EMPTY && !o_pkt_end)
            state <= PACK_HALF;
         else
            state <= PACK_EMPTY;
      end
   end

   // the earlier sample of a pair waits here for its partner
   always_ff @(posedge clk)
   begin
      if (take && (state == PACK_EMPTY))
         holding <= i_sample;
   end

   // maxlen has to be set before samples flow, and pairs need room for two
   a_maxlen_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
      take |-> (maxlen >= 16'd2))
      else $error("sample accepted with maxlen below 2");

endmodule

// File: rx_sync_fifo.sv
module rx_sync_fifo #(
   parameter int WIDTH      = 65,
   parameter int DEPTH_LOG2 = 5
) (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  logic                  i_clear,
   input  logic                  i_wr_en,
   input  logic [WIDTH-1:0]      i_wr_data,
   input  logic                  i_rd_en,
   output logic [WIDTH-1:0]      o_rd_data,
   output logic                  o_not_empty,
   output logic                  o_full,
   output rx_framer_pkg::space_t o_space
);
   import rx_framer_pkg::*;

   localparam int DEPTH = 1 << DEPTH_LOG2;

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic                  do_wr;
   logic                  do_rd;

   assign do_wr = i_wr_en && !o_full;
   assign do_rd = i_rd_en && o_not_empty;

   always_ff @(posedge clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else if (i_clear)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= i_wr_data;
   end

   // the head entry is read straight from the storage registers
   assign o_rd_data   = mem[rd_ptr];
   assign o_not_empty = (count != '0);
   assign o_full      = (count == DEPTH);
   assign o_space     = space_t'(DEPTH) - space_t'(count);

   // the writer and the reader both follow the flags of the store
   a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_wr_en && o_full))
      else $error("write into a full store");

   a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_rd_en && !o_not_empty))
      else $error("read from an empty store");

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen #(
   parameter int PERIOD = 20
) (
   output logic o_clk
);

   initial
   begin
      o_clk = 1'b0;
      forever #(PERIOD / 2) o_clk = ~o_clk;
   end

endmodule

// File: tb_rx_framer.sv
module tb_rx_framer;
   import rx_framer_pkg::*;

   localparam int NUM_CASES     = 7;
   localparam int MARGIN_CYCLES = 1000;
   localparam int CREDIT_DELAY  = 3;
   localparam int HOLD_CYCLES   = 16;

   logic       clk;
   logic       i_rst_n;
   logic       i_clear;
   logic       i_set_stb;
   logic [7:0] i_set_addr;
   logic [31:0] i_set_data;
   logic       i_strobe;
   sample_t    i_sample;
   logic       i_run;
   logic       i_eob;
   vita_time_t i_vita_time;
   logic       o_full;
   seqnum_t    o_seqnum;
   logic       o_valid;
   beat_t      o_data;
   logic       o_last;
   logic       i_credit;

   // the case table holds one row per index
   string case_name     [NUM_CASES];
   int    case_maxlen   [NUM_CASES];
   int    case_count    [NUM_CASES];
   bit    case_eob      [NUM_CASES];
   bit    case_sid_wr   [NUM_CASES];
   sid_t  case_sid      [NUM_CASES];
   bit    case_clear    [NUM_CASES];
   bit    case_withhold [NUM_CASES];

   string       cur_name;
   int          errors = 0;
   int          checks = 0;
   bit          cases_loaded = 1'b0;
   bit          withhold = 1'b0;
   int unsigned rnd;

   // reference model state and the beats it predicts
   beat_t      exp_data [$];
   bit         exp_last [$];
   sample_t    pkt_samples [$];
   vita_time_t pkt_time;
   seqnum_t    m_seq;
   sid_t       m_sid;

   // credit return bookkeeping
   int credit_due [$];
   int mon_cycle   = 0;
   int outstanding = 0;

   tb_clock_gen #(.PERIOD(20)) clock_gen (.o_clk(clk));

   rx_framer_top UUT (
      .clk(clk), .i_rst_n(i_rst_n), .i_clear(i_clear),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_strobe(i_strobe), .i_sample(i_sample), .i_run(i_run), .i_eob(i_eob),
      .i_vita_time(i_vita_time), .o_full(o_full), .o_seqnum(o_seqnum),
      .o_valid(o_valid), .o_data(o_data), .o_last(o_last), .i_credit(i_credit)
   );

   task automatic check_value(input string what, input beat_t expected, input beat_t actual);
      checks++;
      if (expected !== actual)
      begin
         errors++;
         $display("** Error [%s] %s: expected %h, actual %h", cur_name, what, expected, actual);
      end
   endtask

   task automatic add_case(input int idx, input string name, input int maxlen, input int count,
                           input bit eob, input bit sid_wr, input sid_t sid, input bit clear,
                           input bit hold);
      case_name[idx]     = name;
      case_maxlen[idx]   = maxlen;
      case_count[idx]    = count;
      case_eob[idx]      = eob;
      case_sid_wr[idx]   = sid_wr;
      case_sid[idx]      = sid;
      case_clear[idx]    = clear;
      case_withhold[idx] = hold;
   endtask

   task automatic load_cases;
      add_case(0, "odd_eob",        64,  7, 1, 1, 32'h5a00_0011, 0, 0);
      add_case(1, "split_maxlen",    4, 14, 1, 0, 32'h0,         0, 0);
      add_case(2, "exact_no_eob",    5, 10, 0, 0, 32'h0,         0, 0);
      add_case(3, "sid_restart",     3,  9, 1, 1, 32'h5a00_0022, 0, 0);
      add_case(4, "clear_restart",   6, 13, 1, 0, 32'h0,         1, 0);
      add_case(5, "withhold_full", 100, 80, 1, 0, 32'h0,         0, 1);
      add_case(6, "short_packets",   2, 21, 1, 0, 32'h0,         0, 0);
   endtask

   // every stimulus wait goes through here so the timestamp counts each cycle
   task automatic next_cycle;
      @(negedge clk);
      i_vita_time = i_vita_time + 64'd1;
   endtask

   task automatic drive_idle;
      i_strobe = 1'b0;
      i_run    = 1'b1;
      i_eob    = 1'b0;
      i_sample = '0;
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      next_cycle;
      i_set_stb  = 1'b1;
      i_set_addr = addr;
      i_set_data = data;
      next_cycle;
      i_set_stb  = 1'b0;
   endtask

   // header, timestamp, then pairs with the earlier sample on top
   task automatic close_packet(input bit eob);
      int    n;
      beat_t body;
      n = pkt_samples.size();
      exp_data.push_back({HDR_FLAGS, eob, m_seq, pkt_len_t'(n), m_sid});
      exp_last.push_back(1'b0);
      exp_data.push_back(pkt_time);
      exp_last.push_back(1'b0);
      for (int i = 0; i < n; i += 2)
      begin
         body[63:32] = pkt_samples[i];
         body[31:0]  = (i + 1 < n) ? pkt_samples[i + 1] : 32'h0;
         exp_data.push_back(body);
         exp_last.push_back(i + 2 >= n);
      end
      m_seq = m_seq + 12'd1;
      pkt_samples.delete();
   endtask

   task automatic model_accept(input sample_t s, input bit eob, input bit full, input int maxlen);
      if (pkt_samples.size() == 0)
         pkt_time = i_vita_time;
      pkt_samples.push_back(s);
      if (eob || (pkt_samples.size() == maxlen) || full)
         close_packet(eob);
   endtask

   task automatic run_case(input int idx);
      int          sent;
      int          full_cycles;
      bit          full_now;
      bit          full_taken;
      bit          full_seen;
      bit          real_sample;
      int unsigned r;
      cur_name    = case_name[idx];
      sent        = 0;
      full_cycles = 0;
      full_taken  = 1'b0;
      full_seen   = 1'b0;
      drive_idle;
      if (case_clear[idx])
      begin
         next_cycle;
         i_clear = 1'b1;
         next_cycle;
         i_clear = 1'b0;
         m_seq   = '0;
         check_value("o_seqnum after clear", 64'd0, o_seqnum);
      end
      write_setting(SET_ADDR_MAXLEN, case_maxlen[idx]);
      if (case_sid_wr[idx])
      begin
         write_setting(SET_ADDR_SID, case_sid[idx]);
         m_sid = case_sid[idx];
         m_seq = '0;
         check_value("o_seqnum after sid write", 64'd0, o_seqnum);
      end
      withhold <= case_withhold[idx];
      while (sent < case_count[idx])
      begin
         next_cycle;
         drive_idle;
         full_now    = o_full;
         real_sample = 1'b0;
         if (full_now)
         begin
            // one sample is let through while full to close the open packet
            full_seen = 1'b1;
            full_cycles++;
            if (withhold && !full_taken)
            begin
               real_sample = 1'b1;
               full_taken  = 1'b1;
            end
            if (full_cycles >= HOLD_CYCLES)
               withhold <= 1'b0;
         end
         else
         begin
            full_taken  = 1'b0;
            full_cycles = 0;
            r = $urandom % 4;
            if (r == 1)
            begin
               // strobe with run low must leave no trace
               i_strobe = 1'b1;
               i_run    = 1'b0;
               i_eob    = 1'b1;
               i_sample = $urandom;
            end
            else if (r >= 2)
               real_sample = 1'b1;
         end
         if (real_sample)
         begin
            i_strobe = 1'b1;
            i_run    = 1'b1;
            i_sample = $urandom;
            i_eob    = case_eob[idx] && (sent == case_count[idx] - 1);
            model_accept(i_sample, i_eob, full_now, case_maxlen[idx]);
            sent++;
         end
      end
      next_cycle;
      drive_idle;
      withhold <= 1'b0;
      if (case_withhold[idx] && !full_seen)
      begin
         errors++;
         $display("[%s] o_full never rose while credits were withheld", cur_name);
      end
      while ((exp_data.size() != 0) || (credit_due.size() != 0))
         next_cycle;
      repeat (4) next_cycle;
      check_value("o_seqnum after drain", m_seq, o_seqnum);
      if (pkt_samples.size() != 0)
      begin
         errors++;
         $display("[%s] the case ended with a packet still open", cur_name);
      end
   endtask

   // outputs settle after the rising edge, so beats are checked on the falling one
   always @(negedge clk)
   begin : credit_monitor
      beat_t exp_beat;
      bit    exp_end;
      if (!i_rst_n)
         i_credit = 1'b0;
      else
      begin
         if (o_valid)
         begin
            outstanding++;
            credit_due.push_back(mon_cycle + CREDIT_DELAY);
            if (outstanding > CREDIT_MAX)
            begin
               errors++;
               $display("[%s] %0d beats outstanding, above the credit limit", cur_name,
                        outstanding);
            end
            if (exp_data.size() == 0)
            begin
               errors++;
               $display("[%s] beat %h arrived when no beat was expected", cur_name, o_data);
            end
            else
            begin
               exp_beat = exp_data.pop_front();
               exp_end  = exp_last.pop_front();
               check_value("beat", exp_beat, o_data);
               check_value("o_last", exp_end, o_last);
            end
         end
         if (!withhold && (credit_due.size() != 0) && (credit_due[0] <= mon_cycle))
         begin
            i_credit = 1'b1;
            outstanding--;
            credit_due.delete(0);
         end
         else
            i_credit = 1'b0;
         mon_cycle++;
      end
   end

   initial
   begin : watchdog
      int total;
      wait (cases_loaded);
      total = 0;
      for (int k = 0; k < NUM_CASES; k++)
         total += case_count[k];
      repeat (total * 8 + MARGIN_CYCLES) @(posedge clk);
      $display("timeout after %0d cycles with %0d beats still expected",
               total * 8 + MARGIN_CYCLES, exp_data.size());
      $display("sim failed");
      $finish;
   end

   initial
   begin
      rnd         = $urandom(32'h539d);
      i_rst_n     = 1'b0;
      i_clear     = 1'b0;
      i_set_stb   = 1'b0;
      i_set_addr  = '0;
      i_set_data  = '0;
      i_strobe    = 1'b0;
      i_sample    = '0;
      i_run       = 1'b0;
      i_eob       = 1'b0;
      i_vita_time = '0;
      i_credit    = 1'b0;
      m_seq       = '0;
      m_sid       = '0;
      cur_name    = "reset";
      load_cases;
      cases_loaded = 1'b1;
      repeat (5) next_cycle;
      i_rst_n = 1'b1;
      check_value("o_valid after reset", 64'd0, o_valid);
      check_value("o_last after reset", 64'd0, o_last);
      check_value("o_full after reset", 64'd0, o_full);
      for (int k = 0; k < NUM_CASES; k++)
         run_case(k);
      $display("errors: %0d in %0d checks", errors, checks);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// File: vlog.f
rx_framer_pkg.sv
rx_sync_fifo.sv
rx_sample_packer.sv
rx_header_recorder.sv
rx_packet_assembler.sv
rx_framer_top.sv
tb_clock_gen.sv
tb_rx_framer.sv
